/* read_master_pkg.sv */
// Burst read engine shared definitions
// Widths, burst geometry, outstanding budget and buffer sizing
// Vector types used between the blocks of the read engine
package read_master_pkg;

  ////////////////////////////////////////
  // Interface widths
  ////////////////////////////////////////
  localparam int ADDR_W      = 64;
  localparam int DATA_W      = 32;
  localparam int XFER_SIZE_W = 32;

  ////////////////////////////////////////
  // Burst geometry
  ////////////////////////////////////////
  // Protocol limits on a single AXI4 burst
  localparam int MAX_BURST_LEN   = 256;
  localparam int MAX_BURST_BYTES = 4096;
  localparam int BEAT_BYTES      = DATA_W / 8;
  localparam int BEAT_IDX_W      = $clog2(BEAT_BYTES);
  // Smaller of the beat limit and the 4 KB page limit
  localparam int BURST_BEATS     = (MAX_BURST_BYTES / BEAT_BYTES < MAX_BURST_LEN) ?
                                   MAX_BURST_BYTES / BEAT_BYTES : MAX_BURST_LEN;
  localparam int BURST_IDX_W     = $clog2(BURST_BEATS);
  localparam int BURST_BYTES     = BURST_BEATS * BEAT_BYTES;
  // Beat count width after dropping the byte index
  localparam int TOTAL_BEATS_W   = XFER_SIZE_W - BEAT_IDX_W;
  localparam int BURST_CNT_W     = TOTAL_BEATS_W - BURST_IDX_W;

  ////////////////////////////////////////
  // Outstanding budget and buffer
  ////////////////////////////////////////
  localparam int MAX_OUTSTANDING = 4;
  localparam int VACANCY_W       = $clog2(MAX_OUTSTANDING + 1);
  // Room for every beat of every burst in flight
  localparam int FIFO_DEPTH      = BURST_BEATS * MAX_OUTSTANDING;
  localparam int FIFO_PTR_W      = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [DATA_W-1:0]        data_t;
  typedef logic [XFER_SIZE_W-1:0]   xfer_size_t;
  typedef logic [TOTAL_BEATS_W-1:0] beat_cnt_t;
  typedef logic [BURST_CNT_W-1:0]   burst_cnt_t;
  typedef logic [BURST_IDX_W-1:0]   burst_len_t;
  typedef logic [VACANCY_W-1:0]     vacancy_t;
  typedef logic [FIFO_PTR_W-1:0]    fifo_ptr_t;

  // Low address bits inside one full burst
  localparam addr_t BURST_ADDR_MASK = addr_t'(BURST_BYTES - 1);

endpackage

/* rd_job_if.sv */
// Decoded read job
// Carries the job from the setup stage to the address issuer
// and to the R-channel completion tracker
`timescale 1ns/1ps

interface rd_job_if;

  // One-cycle job start
  logic                        start;
  // Aligned first burst address
  read_master_pkg::addr_t      base_addr;
  // Number of bursts minus one
  read_master_pkg::burst_cnt_t last_burst_idx;
  // arlen of the final burst
  read_master_pkg::burst_len_t final_len;

  modport setup (output start, output base_addr, output last_burst_idx, output final_len);

  modport issue (input start, input base_addr, input last_burst_idx, input final_len);

  // Completion side only needs the burst count
  modport track (input start, input last_burst_idx);

endinterface

/* xfer_setup.sv */
// Transfer setup
// Registers the control request and decodes it into a read job
// First stage rounds the size to beats and aligns the address
// Second stage splits the beats into bursts and fires the job start
`timescale 1ns/1ps

module xfer_setup (
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        ctrl_start,
  input  read_master_pkg::addr_t      ctrl_addr_offset,
  input  read_master_pkg::xfer_size_t ctrl_xfer_size_in_bytes,
  rd_job_if.setup                     job
);

  logic                       start_d1;
  // Total beats minus one
  read_master_pkg::beat_cnt_t total_len_r;
  read_master_pkg::addr_t     addr_aligned_r;

  ////////////////////////////////////////
  // Stage 1, capture on ctrl_start
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // A partial last beat counts as a whole beat, so no minus one then
      total_len_r <= (ctrl_xfer_size_in_bytes[read_master_pkg::BEAT_IDX_W-1:0] != '0) ?
        ctrl_xfer_size_in_bytes[read_master_pkg::XFER_SIZE_W-1:read_master_pkg::BEAT_IDX_W] :
        ctrl_xfer_size_in_bytes[read_master_pkg::XFER_SIZE_W-1:read_master_pkg::BEAT_IDX_W]
          - 1'b1;
      // Clear the offset inside one burst
      addr_aligned_r <= ctrl_addr_offset & ~read_master_pkg::BURST_ADDR_MASK;
    end
  end

  ////////////////////////////////////////
  // Stage 2, split into bursts
  ////////////////////////////////////////
  // Job fields held until the next job
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      job.base_addr      <= addr_aligned_r;
      job.last_burst_idx <= total_len_r[read_master_pkg::TOTAL_BEATS_W-1:
                                        read_master_pkg::BURST_IDX_W];
      job.final_len      <= total_len_r[read_master_pkg::BURST_IDX_W-1:0];
    end
  end

  // Two-stage delay of ctrl_start
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1  <= 1'b0;
      job.start <= 1'b0;
    end else begin
      start_d1  <= ctrl_start;
      job.start <= start_d1;
    end
  end

endmodule

/* ar_issue.sv */
// Read address issuer
// Walks the job burst by burst on the AXI4 AR channel
// Holds a budget of outstanding bursts so the data buffer never overflows
// A slot comes back each time a full burst leaves on the stream
`timescale 1ns/1ps

module ar_issue (
  input  logic                        aclk,
  input  logic                        areset,
  rd_job_if.issue                     job,
  input  logic                        burst_drained,
  output logic                        m_axi_arvalid,
  input  logic                        m_axi_arready,
  output read_master_pkg::addr_t      m_axi_araddr,
  output read_master_pkg::burst_len_t m_axi_arlen
);

  logic                        ar_idle;
  logic                        arxfer;
  logic                        ar_final;
  logic                        ar_done;
  logic                        stall_ar;
  read_master_pkg::addr_t      addr;
  read_master_pkg::burst_cnt_t bursts_to_go;
  read_master_pkg::vacancy_t   vacancy;

  assign arxfer  = m_axi_arvalid & m_axi_arready;
  // Count reaches zero on the last burst of the job
  assign ar_final = (bursts_to_go == '0);
  assign ar_done  = ar_final & arxfer;
  assign stall_ar = (vacancy == '0);

  ////////////////////////////////////////
  // AR channel outputs
  ////////////////////////////////////////
  assign m_axi_araddr = addr;
  // Full length except on the final burst
  assign m_axi_arlen  = ar_final ? job.final_len :
                                   read_master_pkg::burst_len_t'(read_master_pkg::BURST_BEATS - 1);

  // Raise valid only from low, so one idle cycle follows every accepted address
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (!ar_idle && !stall_ar && !m_axi_arvalid) begin
      m_axi_arvalid <= 1'b1;
    end else if (m_axi_arready) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Job progress
  ////////////////////////////////////////
  // Nothing to issue while idle
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (job.start) begin
      ar_idle <= 1'b0;
    end else if (ar_done) begin
      ar_idle <= 1'b1;
    end
  end

  // Next burst address
  always_ff @(posedge aclk) begin
    if (job.start) begin
      addr <= job.base_addr;
    end else if (arxfer) begin
      addr <= addr + read_master_pkg::addr_t'(read_master_pkg::BURST_BYTES);
    end
  end

  // Bursts left after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_to_go <= '0;
    end else if (job.start) begin
      bursts_to_go <= job.last_burst_idx;
    end else if (arxfer && !ar_final) begin
      bursts_to_go <= bursts_to_go - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Outstanding budget
  ////////////////////////////////////////
  // Issue and drain in one cycle cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= read_master_pkg::vacancy_t'(read_master_pkg::MAX_OUTSTANDING);
    end else if (arxfer && !burst_drained) begin
      vacancy <= vacancy - 1'b1;
    end else if (burst_drained && !arxfer) begin
      vacancy <= vacancy + 1'b1;
    end
  end

endmodule

/* read_data_fifo.sv */
// Read data buffer
// First-word-fall-through store between the R channel and the stream
// Sized for every outstanding burst, so a write is never refused
// Flags each burst as its last beat leaves on the stream
`timescale 1ns/1ps

module read_data_fifo (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   m_axi_rvalid,
  input  read_master_pkg::data_t m_axi_rdata,
  input  logic                   m_axi_rlast,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output read_master_pkg::data_t m_axis_tdata,
  output logic                   m_axis_tlast,
  output logic                   burst_drained
);

  // Entry is {last, data}
  logic [read_master_pkg::DATA_W:0] mem [read_master_pkg::FIFO_DEPTH];

  read_master_pkg::fifo_ptr_t              wr_ptr;
  read_master_pkg::fifo_ptr_t              rd_ptr;
  // One bit wider than a pointer to hold a full buffer
  logic [read_master_pkg::FIFO_PTR_W:0]    count;
  logic                                    wr_en;
  logic                                    rd_en;

  assign wr_en = m_axi_rvalid;
  assign rd_en = m_axis_tvalid & m_axis_tready;

  // Storage
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {m_axi_rlast, m_axi_rdata};
    end
  end

  // Head entry falls through whenever the buffer holds data
  assign m_axis_tvalid                  = (count != '0);
  assign {m_axis_tlast, m_axis_tdata}   = mem[rd_ptr];
  assign burst_drained                  = rd_en & m_axis_tlast;

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////
  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* r_completion_tracker.sv */
// R-channel completion tracker
// Counts bursts coming back on the R channel against the job
// Pulses done for one cycle after the final rlast beat
`timescale 1ns/1ps

module r_completion_tracker (
  input  logic    aclk,
  input  logic    areset,
  rd_job_if.track job,
  input  logic    m_axi_rvalid,
  input  logic    m_axi_rlast,
  output logic    ctrl_done
);

  read_master_pkg::burst_cnt_t r_bursts_to_go;
  logic                        burst_end;
  logic                        r_final;

  // Every rvalid cycle is a transfer, ready is tied high
  assign burst_end = m_axi_rvalid & m_axi_rlast;
  assign r_final   = (r_bursts_to_go == '0);

  // Bursts still expected after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      r_bursts_to_go <= '0;
    end else if (job.start) begin
      r_bursts_to_go <= job.last_burst_idx;
    end else if (burst_end && !r_final) begin
      r_bursts_to_go <= r_bursts_to_go - 1'b1;
    end
  end

  // One-cycle pulse, no further rlast until the next job
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= burst_end & r_final;
    end
  end

endmodule

/* read_master_top.sv */
// Burst read engine top level
// Loads an address and byte count, reads memory over AXI4 in bursts
// and returns the data on an AXI4-Stream master port
// R data lands in an internal buffer, so rready stays high
`timescale 1ns/1ps

module read_master_top (
  input  logic                        aclk,
  input  logic                        areset,
  // Control
  input  logic                        ctrl_start,
  input  read_master_pkg::addr_t      ctrl_addr_offset,
  input  read_master_pkg::xfer_size_t ctrl_xfer_size_in_bytes,
  output logic                        ctrl_done,
  // AXI4 read address channel
  output logic                        m_axi_arvalid,
  input  logic                        m_axi_arready,
  output read_master_pkg::addr_t      m_axi_araddr,
  output read_master_pkg::burst_len_t m_axi_arlen,
  // AXI4 read data channel
  input  logic                        m_axi_rvalid,
  output logic                        m_axi_rready,
  input  read_master_pkg::data_t      m_axi_rdata,
  input  logic                        m_axi_rlast,
  // AXI4-Stream master
  output logic                        m_axis_tvalid,
  input  logic                        m_axis_tready,
  output read_master_pkg::data_t      m_axis_tdata,
  output logic                        m_axis_tlast
);

  rd_job_if job_if ();

  // Budget slot returned by the buffer
  logic burst_drained;

  // Buffer always has room for what was issued
  assign m_axi_rready = 1'b1;

  ////////////////////////////////////////
  // Request path
  ////////////////////////////////////////
  xfer_setup u_xfer_setup (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .job                     (job_if.setup)
  );

  ar_issue u_ar_issue (
    .aclk          (aclk),
    .areset        (areset),
    .job           (job_if.issue),
    .burst_drained (burst_drained),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  ////////////////////////////////////////
  // Data path
  ////////////////////////////////////////
  read_data_fifo u_read_data_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rlast   (m_axi_rlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_drained (burst_drained)
  );

  r_completion_tracker u_r_completion_tracker (
    .aclk         (aclk),
    .areset       (areset),
    .job          (job_if.track),
    .m_axi_rvalid (m_axi_rvalid),
    .m_axi_rlast  (m_axi_rlast),
    .ctrl_done    (ctrl_done)
  );

endmodule

/* read_master_assertions.sv */
// AR channel checks for the read address issuer
// Bound into ar_issue, watches the address handshake and the budget
`timescale 1ns/1ps

module read_master_assertions (
  input logic                        aclk,
  input logic                        areset,
  input logic                        arvalid,
  input logic                        arready,
  input read_master_pkg::addr_t      araddr,
  input read_master_pkg::burst_len_t arlen,
  input read_master_pkg::vacancy_t   vacancy
);

  // Failures seen so far, read by the testbench monitor
  int fail_count = 0;

  // Held request keeps valid, address and length until accepted
  ar_hold_stable: assert property (@(posedge aclk) disable iff (areset)
    (arvalid && !arready) |=> (arvalid && $stable(araddr) && $stable(arlen)))
    else begin
      $error("AR request changed before arready");
      fail_count++;
    end

  // Every burst starts on a 1 KB boundary
  ar_addr_aligned: assert property (@(posedge aclk) disable iff (areset)
    arvalid |-> ((araddr & read_master_pkg::BURST_ADDR_MASK) == '0))
    else begin
      $error("araddr not burst aligned");
      fail_count++;
    end

  // Budget stays in range, a wrap below zero shows as a large value
  vacancy_in_range: assert property (@(posedge aclk) disable iff (areset)
    vacancy <= read_master_pkg::vacancy_t'(read_master_pkg::MAX_OUTSTANDING))
    else begin
      $error("outstanding budget out of range");
      fail_count++;
    end

  // No request while the budget is used up
  no_ar_when_full: assert property (@(posedge aclk) disable iff (areset)
    (vacancy == '0) |-> !arvalid)
    else begin
      $error("arvalid high with no budget left");
      fail_count++;
    end

endmodule

bind ar_issue read_master_assertions u_ar_checks (
  .aclk    (aclk),
  .areset  (areset),
  .arvalid (m_axi_arvalid),
  .arready (m_axi_arready),
  .araddr  (m_axi_araddr),
  .arlen   (m_axi_arlen),
  .vacancy (vacancy)
);

/* tb_read_master_top.sv */
// Testbench for the burst read engine
// Random jobs from an LCG, an AXI4 memory slave model with random gaps
// and a stream checker fed from a queue of expected beats
`timescale 1ns/1ps

module tb_read_master_top;

  localparam int NUM_JOBS       = 20;
  localparam int MAX_SIZE       = 8192;
  localparam int MAX_IN_FLIGHT  = 4;
  // 20 jobs of up to 2048 beats at a few cycles per beat under back-pressure
  localparam int TIMEOUT_CYCLES = 200000;
  localparam logic [31:0] DATA_XOR = 32'h5a3c_96e1;

  logic                        aclk;
  logic                        areset;
  logic                        ctrl_start;
  read_master_pkg::addr_t      ctrl_addr_offset;
  read_master_pkg::xfer_size_t ctrl_xfer_size_in_bytes;
  logic                        ctrl_done;
  logic                        m_axi_arvalid;
  logic                        m_axi_arready;
  read_master_pkg::addr_t      m_axi_araddr;
  read_master_pkg::burst_len_t m_axi_arlen;
  logic                        m_axi_rvalid;
  logic                        m_axi_rready;
  read_master_pkg::data_t      m_axi_rdata;
  logic                        m_axi_rlast;
  logic                        m_axis_tvalid;
  logic                        m_axis_tready;
  read_master_pkg::data_t      m_axis_tdata;
  logic                        m_axis_tlast;

  logic [31:0]                 lcg_state;
  int                          cycles;
  read_master_pkg::addr_t      job_offset [NUM_JOBS];
  read_master_pkg::xfer_size_t job_size [NUM_JOBS];
  // Expected AR requests and stream beats
  read_master_pkg::addr_t      exp_ar_addr [$];
  read_master_pkg::burst_len_t exp_ar_len [$];
  read_master_pkg::data_t      exp_data [$];
  logic                        exp_last [$];
  // Bursts accepted by the slave model and still to return
  read_master_pkg::addr_t      rd_addr_q [$];
  read_master_pkg::burst_len_t rd_len_q [$];
  int                          r_beat;
  int                          ready_low_run;
  int                          job_bursts;
  int                          rlast_cnt;
  int                          done_cnt;
  logic                        done_due;
  longint                      ar_cnt;
  longint                      tlast_cnt;

  read_master_top dut0 (.*);

  always #2 aclk = ~aclk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Memory content is the low address bits XOR a pattern
  function automatic read_master_pkg::data_t beat_value(read_master_pkg::addr_t addr);
    return addr[31:0] ^ DATA_XOR;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first failed check");
  endtask

  // Expected bursts and beats of one job
  task automatic build_expected(input read_master_pkg::addr_t offset,
                                input read_master_pkg::xfer_size_t size);
    int                     beats;
    int                     len;
    read_master_pkg::addr_t burst_addr;
    beats      = (int'(size) + 3) / 4;
    job_bursts = (beats + 255) / 256;
    for (int b = 0; b < job_bursts; b++) begin
      burst_addr = (offset & ~64'h3ff) + 64'(b * 1024);
      len        = (b == job_bursts - 1) ? (beats - 1) % 256 : 255;
      exp_ar_addr.push_back(burst_addr);
      exp_ar_len.push_back(8'(len));
      for (int k = 0; k <= len; k++) begin
        exp_data.push_back(beat_value(burst_addr + 64'(k * 4)));
        exp_last.push_back(k == len);
      end
    end
  endtask

  ////////////////////////////////////////
  // Memory slave and stream sink
  ////////////////////////////////////////
  always @(negedge aclk) begin
    logic [31:0] r;
    if (areset) begin
      m_axi_arready = 1'b0;
      m_axi_rvalid  = 1'b0;
      m_axi_rlast   = 1'b0;
      m_axis_tready = 1'b0;
    end else begin
      r = next_random();
      m_axi_arready = r[31];
      r = next_random();
      // Beats go out in order on about three cycles in four
      if (rd_addr_q.size() > 0 && r[31:30] != 2'b00) begin
        m_axi_rvalid = 1'b1;
        m_axi_rdata  = beat_value(rd_addr_q[0] + 64'(r_beat * 4));
        m_axi_rlast  = (r_beat == int'(rd_len_q[0]));
        if (m_axi_rlast) begin
          void'(rd_addr_q.pop_front());
          void'(rd_len_q.pop_front());
          r_beat = 0;
        end else begin
          r_beat++;
        end
      end else begin
        m_axi_rvalid = 1'b0;
        m_axi_rlast  = 1'b0;
      end
      r = next_random();
      // Occasional long runs of tready low
      if (ready_low_run > 0) begin
        m_axis_tready = 1'b0;
        ready_low_run--;
      end else if (r[31:28] == 4'h0) begin
        m_axis_tready = 1'b0;
        ready_low_run = 3 + int'(r[5:0]);
      end else begin
        m_axis_tready = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Monitor sampled at the rising edge
  ////////////////////////////////////////
  always @(posedge aclk) begin
    if (!areset) begin
      assert (dut0.u_ar_issue.u_ar_checks.fail_count == 0)
        else report_mismatch("bound AR channel assertion failed");
      assert (m_axi_rready == 1'b1) else report_mismatch("rready not held high");
      assert (ctrl_done == done_due)
        else report_mismatch($sformatf("ctrl_done %b, expected %b", ctrl_done, done_due));
      if (ctrl_done) begin
        done_cnt++;
      end
      // Done follows the edge that takes the final rlast
      done_due = 1'b0;
      if (m_axi_rvalid && m_axi_rlast) begin
        rlast_cnt++;
        done_due = (rlast_cnt == job_bursts);
      end
      if (m_axi_arvalid && m_axi_arready) begin
        assert (exp_ar_addr.size() > 0) else report_mismatch("unexpected AR request");
        assert (m_axi_araddr == exp_ar_addr[0])
          else report_mismatch($sformatf("araddr %h, expected %h", m_axi_araddr,
                                         exp_ar_addr[0]));
        assert (m_axi_arlen == exp_ar_len[0])
          else report_mismatch($sformatf("arlen %0d, expected %0d", m_axi_arlen,
                                         exp_ar_len[0]));
        rd_addr_q.push_back(m_axi_araddr);
        rd_len_q.push_back(m_axi_arlen);
        void'(exp_ar_addr.pop_front());
        void'(exp_ar_len.pop_front());
        ar_cnt++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        assert (exp_data.size() > 0) else report_mismatch("unexpected stream beat");
        assert (m_axis_tdata == exp_data[0] && m_axis_tlast == exp_last[0])
          else report_mismatch($sformatf("tdata %h tlast %b, expected %h %b", m_axis_tdata,
                                         m_axis_tlast, exp_data[0], exp_last[0]));
        void'(exp_data.pop_front());
        void'(exp_last.pop_front());
        if (m_axis_tlast) begin
          tlast_cnt++;
        end
      end
      assert (ar_cnt - tlast_cnt <= MAX_IN_FLIGHT)
        else report_mismatch($sformatf("%0d bursts in flight", ar_cnt - tlast_cnt));
    end
  end

  // Run limit
  always @(posedge aclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "Run limit reached");
    end
  end

  ////////////////////////////////////////
  // Job sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] hi;
    logic [31:0] lo;
    aclk                    = 1'b0;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    m_axi_arready           = 1'b0;
    m_axi_rvalid            = 1'b0;
    m_axi_rdata             = '0;
    m_axi_rlast             = 1'b0;
    m_axis_tready           = 1'b0;
    lcg_state               = 32'h4eca;
    cycles                  = 0;
    r_beat                  = 0;
    ready_low_run           = 0;
    job_bursts              = 0;
    rlast_cnt               = 0;
    done_cnt                = 0;
    done_due                = 1'b0;
    ar_cnt                  = 0;
    tlast_cnt               = 0;
    // Job list drawn before the clock runs
    for (int j = 0; j < NUM_JOBS; j++) begin
      hi = next_random();
      job_size[j] = 32'((hi >> 8) % MAX_SIZE + 1);
      hi = next_random();
      lo = next_random();
      job_offset[j] = {hi, lo};
    end
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    areset = 1'b0;
    assert (!m_axi_arvalid && !m_axis_tvalid && !ctrl_done)
      else report_mismatch("outputs not low after reset");
    for (int j = 0; j < NUM_JOBS; j++) begin
      build_expected(job_offset[j], job_size[j]);
      rlast_cnt               = 0;
      done_cnt                = 0;
      ctrl_start              = 1'b1;
      ctrl_addr_offset        = job_offset[j];
      ctrl_xfer_size_in_bytes = job_size[j];
      @(negedge aclk);
      ctrl_start = 1'b0;
      // Done seen and every expected beat drained
      while (!(done_cnt > 0 && exp_data.size() == 0 && exp_ar_addr.size() == 0)) begin
        @(negedge aclk);
      end
    end
    repeat (8) @(negedge aclk);
    $display("TEST OK");
    $finish;
  end

endmodule

/* read_master_top.f */
read_master_pkg.sv
rd_job_if.sv
xfer_setup.sv
ar_issue.sv
read_data_fifo.sv
r_completion_tracker.sv
read_master_top.sv
read_master_assertions.sv
tb_read_master_top.sv
